//--- rtl/pipe_defines.svh
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// register index and word widths
`define NB_REG        5
`define NB_WORD       32
`define NB_OP         6

// instruction memory, word addressed
`define IMEM_DEPTH    64
`define NB_IMEM_ADDR  6

// field msb positions in the instruction word
`define OP_MSB        31
`define RS_MSB        25
`define RT_MSB        20
`define RD_MSB        15

`endif

//--- rtl/pipe_pkg.sv
`default_nettype none
`include "pipe_defines.svh"

package pipe_pkg;

   // primary opcodes, mips numbering where one exists
   typedef enum logic [`NB_OP-1:0] {
      OP_ALU   = 6'h00, // rd <- rs op rt
      OP_BEQ   = 6'h04, // compares rs and rt
      OP_JR    = 6'h08, // target from rs
      OP_LOAD  = 6'h23, // rt <- mem[rs]
      OP_STORE = 6'h2b, // mem[rs] <- rt
      OP_NOP   = 6'h3e,
      OP_HALT  = 6'h3f  // stops fetch
   } opcode_e;

   // hazard class as seen by the bubble unit
   typedef enum logic [1:0] {
      CL_PLAIN,
      CL_LOAD,
      CL_BRANCH,
      CL_JUMP
   } iclass_e;

endpackage

`default_nettype wire

//--- rtl/if_id_bus.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

interface if_id_bus;

   logic [`NB_WORD-1:0] pc;    // address of instr
   logic [`NB_WORD-1:0] instr; // raw word
   logic                valid; // word present
   logic                we;    // low while stalled

   // fetch side, sees the stall
   modport fetch_mp (output pc, instr, valid, input we);

   // buffer input side
   modport buf_in_mp (input pc, instr, valid, we);

   // buffer output toward decode
   modport buf_out_mp (output pc, instr, valid);

endinterface

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module fetch_stage (
   input  wire                      i_clk,
   input  wire                      i_rst_n,
   input  wire                      i_imem_we,   // program load port
   input  wire [`NB_IMEM_ADDR-1:0]  i_imem_addr, // word index
   input  wire [`NB_WORD-1:0]       i_imem_data,
   input  wire                      i_start,     // one cycle pulse
   input  wire                      i_halt,      // halt issuing in decode
   if_id_bus.fetch_mp               bus
);

   logic [`NB_WORD-1:0]      imem [`IMEM_DEPTH];
   logic [`NB_WORD-1:0]      pc_q;    // byte address
   logic                     run_q;
   logic [`NB_IMEM_ADDR-1:0] rd_addr;
   pipe_pkg::opcode_e        if_op;   // opcode of the word in IF

   always_ff @(posedge i_clk) begin
      if (i_imem_we)
         imem[i_imem_addr] <= i_imem_data;
   end

   assign rd_addr = pc_q[`NB_IMEM_ADDR+1:2]; // drop byte offset
   assign if_op   = pipe_pkg::opcode_e'(imem[rd_addr][`OP_MSB -: `NB_OP]);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         pc_q  <= '0;
         run_q <= 1'b0;
      end else if (i_start) begin
         pc_q  <= '0;     // restart from word 0
         run_q <= 1'b1;
      end else if (i_halt) begin
         run_q <= 1'b0;   // halt reached decode
      end else if (run_q && bus.we && if_op != pipe_pkg::OP_HALT) begin
         pc_q  <= pc_q + `NB_WORD'd4;
      end
      // pc parks on a halt word until decode stops us
   end

   assign bus.pc    = pc_q;
   assign bus.instr = imem[rd_addr]; // async read
   assign bus.valid = run_q;

endmodule

`default_nettype wire

//--- rtl/if_id_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module if_id_buffer (
   input  wire             i_clk,
   input  wire             i_rst_n,
   input  wire             i_we,    // from bubble unit
   input  wire             i_flush, // halt issuing this cycle
   if_id_bus.buf_in_mp     bus_in,
   if_id_bus.buf_out_mp    bus_out
);

   logic [`NB_WORD-1:0] pc_q;
   logic [`NB_WORD-1:0] instr_q;
   logic                valid_q;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         valid_q <= 1'b0;
      else if (i_flush)
         valid_q <= 1'b0;        // drop the word behind halt
      else if (i_we)
         valid_q <= bus_in.valid;
   end

   // payload only moves with the enable
   always_ff @(posedge i_clk) begin
      if (i_we) begin
         pc_q    <= bus_in.pc;
         instr_q <= bus_in.instr;
      end
   end

   assign bus_out.pc    = pc_q;
   assign bus_out.instr = instr_q;
   assign bus_out.valid = valid_q;

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module decode_stage (
   input  wire                   i_clk,
   input  wire                   i_rst_n,
   if_id_bus.buf_out_mp          bus,
   input  wire                   i_bubble,
   output logic [`NB_REG-1:0]    o_rs,       // zero when not read
   output logic [`NB_REG-1:0]    o_rt,       // zero when not read
   output pipe_pkg::iclass_e     o_class,
   output logic                  o_id_valid,
   output logic [`NB_REG-1:0]    o_dst,
   output logic                  o_dst_we,
   output logic                  o_is_load,
   output logic                  o_halt,     // halt issuing now
   output logic                  o_issue_valid,
   output logic [`NB_WORD-1:0]   o_issue_pc,
   output pipe_pkg::opcode_e     o_issue_op,
   output logic                  o_bubble,
   output logic                  o_halted
);

   pipe_pkg::opcode_e  op;
   logic [`NB_REG-1:0] rs;
   logic [`NB_REG-1:0] rt;
   logic [`NB_REG-1:0] rd;
   logic               issue;

   assign op = pipe_pkg::opcode_e'(bus.instr[`OP_MSB -: `NB_OP]);
   assign rs = bus.instr[`RS_MSB -: `NB_REG];
   assign rt = bus.instr[`RT_MSB -: `NB_REG];
   assign rd = bus.instr[`RD_MSB -: `NB_REG];

   // an unread source is forced to r0, which never matches a writer
   always_comb begin
      o_class = pipe_pkg::CL_PLAIN;
      o_rs    = '0;
      o_rt    = '0;
      o_dst   = '0;
      case (op)
         pipe_pkg::OP_ALU: begin
            o_rs  = rs;
            o_rt  = rt;
            o_dst = rd;
         end
         pipe_pkg::OP_LOAD: begin
            o_class = pipe_pkg::CL_LOAD;
            o_rs    = rs;
            o_dst   = rt;              // load writes rt
         end
         pipe_pkg::OP_STORE: begin
            o_rs = rs;
            o_rt = rt;
         end
         pipe_pkg::OP_BEQ: begin
            o_class = pipe_pkg::CL_BRANCH;
            o_rs    = rs;
            o_rt    = rt;
         end
         pipe_pkg::OP_JR: begin
            o_class = pipe_pkg::CL_JUMP;
            o_rs    = rs;              // rt ignored
         end
         default: ;                    // nop, halt, unknown
      endcase
   end

   assign o_id_valid = bus.valid;
   assign o_dst_we   = bus.valid && (o_dst != '0); // r0 never written
   assign o_is_load  = bus.valid && (o_class == pipe_pkg::CL_LOAD);
   assign issue      = bus.valid && !i_bubble;
   assign o_halt     = issue && (op == pipe_pkg::OP_HALT);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_issue_valid <= 1'b0;
         o_bubble      <= 1'b0;
         o_halted      <= 1'b0;
      end else begin
         o_issue_valid <= issue;
         o_bubble      <= i_bubble;   // lines up with the empty id/ex slot
         if (o_halt)
            o_halted <= 1'b1;         // sticky until reset
      end
   end

   always_ff @(posedge i_clk) begin
      if (issue) begin
         o_issue_pc <= bus.pc;
         o_issue_op <= op;
      end
   end

endmodule

`default_nettype wire

//--- rtl/bubble_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module bubble_unit (
   input  wire [`NB_REG-1:0]      i_rs,
   input  wire [`NB_REG-1:0]      i_rt,
   input  wire pipe_pkg::iclass_e i_class,
   input  wire                    i_id_valid,
   input  wire [`NB_REG-1:0]      i_idc_rd,   // id/ex destination
   input  wire [`NB_REG-1:0]      i_exe_rd,   // ex/mem destination
   input  wire [`NB_REG-1:0]      i_mem_rd,   // mem/wb destination
   input  wire                    i_idc_wfr,
   input  wire                    i_exe_wfr,
   input  wire                    i_mem_wfr,
   input  wire                    i_idc_load, // id/ex holds a load
   output logic                   o_pc_we,
   output logic                   o_if_id_we,
   output logic                   o_bubble
);

   logic idc_rs;    // id/ex writes rs
   logic exe_rs;
   logic mem_rs;
   logic idc_rt;    // id/ex writes rt
   logic exe_rt;
   logic mem_rt;
   logic load_use;
   logic br_haz;
   logic jr_haz;
   logic stall;

   // write flags are low for r0, so an unread source never matches
   assign idc_rs = i_idc_wfr && (i_idc_rd == i_rs);
   assign exe_rs = i_exe_wfr && (i_exe_rd == i_rs);
   assign mem_rs = i_mem_wfr && (i_mem_rd == i_rs);
   assign idc_rt = i_idc_wfr && (i_idc_rd == i_rt);
   assign exe_rt = i_exe_wfr && (i_exe_rd == i_rt);
   assign mem_rt = i_mem_wfr && (i_mem_rd == i_rt);

   assign load_use = i_idc_load && (idc_rs || idc_rt);   // one slot back only
   assign br_haz   = (i_class == pipe_pkg::CL_BRANCH) &&
                     (idc_rs || exe_rs || mem_rs || idc_rt || exe_rt || mem_rt);
   assign jr_haz   = (i_class == pipe_pkg::CL_JUMP) &&
                     (idc_rs || exe_rs || mem_rs);        // rt ignored

   // load-use, then branch, then jump; every case holds pc and if/id alike
   assign stall = i_id_valid && (load_use || br_haz || jr_haz);

   assign o_pc_we    = !stall;
   assign o_if_id_we = !stall;
   assign o_bubble   = stall;   // empty slot into id/ex

endmodule

`default_nettype wire

//--- rtl/stage_tracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module stage_tracker (
   input  wire                 i_clk,
   input  wire                 i_rst_n,
   input  wire [`NB_REG-1:0]   i_dst,      // issued destination
   input  wire                 i_dst_we,   // already low for r0 or no issue
   input  wire                 i_is_load,
   input  wire                 i_bubble,   // empty slot this cycle
   output logic [`NB_REG-1:0]  o_idc_rd,
   output logic [`NB_REG-1:0]  o_exe_rd,
   output logic [`NB_REG-1:0]  o_mem_rd,
   output logic                o_idc_wfr,
   output logic                o_exe_wfr,
   output logic                o_mem_wfr,
   output logic                o_idc_load
);

   // write flags and load flag, cleared on reset
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_idc_wfr  <= 1'b0;
         o_exe_wfr  <= 1'b0;
         o_mem_wfr  <= 1'b0;
         o_idc_load <= 1'b0;
      end else begin
         o_idc_wfr  <= i_dst_we && !i_bubble;  // bubble slot writes nothing
         o_idc_load <= i_is_load && !i_bubble;
         o_exe_wfr  <= o_idc_wfr;
         o_mem_wfr  <= o_exe_wfr;
      end
   end

   // destinations just follow along, flags qualify them
   always_ff @(posedge i_clk) begin
      o_idc_rd <= i_dst;
      o_exe_rd <= o_idc_rd;
      o_mem_rd <= o_exe_rd;
   end

endmodule

`default_nettype wire

//--- rtl/hazard_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module hazard_pipe_top (
   input  wire                      i_clk,
   input  wire                      i_rst_n,
   input  wire                      i_imem_we,
   input  wire [`NB_IMEM_ADDR-1:0]  i_imem_addr,
   input  wire [`NB_WORD-1:0]       i_imem_data,
   input  wire                      i_start,
   output logic                     o_issue_valid,
   output logic [`NB_WORD-1:0]      o_issue_pc,
   output pipe_pkg::opcode_e        o_issue_op,
   output logic                     o_bubble,
   output logic                     o_halted
);

   logic [`NB_REG-1:0] id_rs;
   logic [`NB_REG-1:0] id_rt;
   pipe_pkg::iclass_e  id_class;
   logic               id_valid;
   logic [`NB_REG-1:0] id_dst;
   logic               id_dst_we;
   logic               id_is_load;
   logic               halt;       // halt issuing, stops fetch and flushes if/id
   logic [`NB_REG-1:0] idc_rd;
   logic [`NB_REG-1:0] exe_rd;
   logic [`NB_REG-1:0] mem_rd;
   logic               idc_wfr;
   logic               exe_wfr;
   logic               mem_wfr;
   logic               idc_load;
   logic               if_id_we;
   logic               bubble;

   if_id_bus f2b ();   // fetch to buffer
   if_id_bus b2d ();   // buffer to decode

   fetch_stage u_fetch (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_imem_we   (i_imem_we),
      .i_imem_addr (i_imem_addr),
      .i_imem_data (i_imem_data),
      .i_start     (i_start),
      .i_halt      (halt),
      .bus         (f2b.fetch_mp)
   );

   if_id_buffer u_if_id (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_we    (if_id_we),
      .i_flush (halt),
      .bus_in  (f2b.buf_in_mp),
      .bus_out (b2d.buf_out_mp)
   );

   decode_stage u_decode (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .bus           (b2d.buf_out_mp),
      .i_bubble      (bubble),
      .o_rs          (id_rs),
      .o_rt          (id_rt),
      .o_class       (id_class),
      .o_id_valid    (id_valid),
      .o_dst         (id_dst),
      .o_dst_we      (id_dst_we),
      .o_is_load     (id_is_load),
      .o_halt        (halt),
      .o_issue_valid (o_issue_valid),
      .o_issue_pc    (o_issue_pc),
      .o_issue_op    (o_issue_op),
      .o_bubble      (o_bubble),
      .o_halted      (o_halted)
   );

   // pc write enable rides the fetch bus
   bubble_unit u_bubble (
      .i_rs       (id_rs),
      .i_rt       (id_rt),
      .i_class    (id_class),
      .i_id_valid (id_valid),
      .i_idc_rd   (idc_rd),
      .i_exe_rd   (exe_rd),
      .i_mem_rd   (mem_rd),
      .i_idc_wfr  (idc_wfr),
      .i_exe_wfr  (exe_wfr),
      .i_mem_wfr  (mem_wfr),
      .i_idc_load (idc_load),
      .o_pc_we    (f2b.we),
      .o_if_id_we (if_id_we),
      .o_bubble   (bubble)
   );

   stage_tracker u_tracker (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_dst      (id_dst),
      .i_dst_we   (id_dst_we),
      .i_is_load  (id_is_load),
      .i_bubble   (bubble),
      .o_idc_rd   (idc_rd),
      .o_exe_rd   (exe_rd),
      .o_mem_rd   (mem_rd),
      .o_idc_wfr  (idc_wfr),
      .o_exe_wfr  (exe_wfr),
      .o_mem_wfr  (mem_wfr),
      .o_idc_load (idc_load)
   );

endmodule

`default_nettype wire

//--- sim/tb_hazard_model.svh
// slot model of the bubble rules, fills exp_gap per word and returns the total
function automatic int model_bubbles(input int n);
   logic [`NB_REG-1:0] slot_rd [3];  // id/ex, ex/mem, mem/wb
   logic               slot_w  [3];
   logic               slot_ld;      // id/ex holds a load
   logic [`NB_REG-1:0] src_a;        // r0 when not read
   logic [`NB_REG-1:0] src_b;
   logic [`NB_REG-1:0] dst;
   logic               is_ld;
   logic               ctl;          // branch or jump, waits on all three slots
   logic               hit_a;
   logic               hit_b;
   logic               stall;
   int                 total;
   total   = 0;
   slot_ld = 1'b0;
   for (int s = 0; s < 3; s++) begin
      slot_rd[s] = '0;
      slot_w[s]  = 1'b0;
   end
   for (int i = 0; i < n; i++) begin
      src_a = '0;
      src_b = '0;
      dst   = '0;
      is_ld = 1'b0;
      ctl   = 1'b0;
      case (prog_op[i])
         pipe_pkg::OP_ALU: begin
            src_a = prog_rs[i];
            src_b = prog_rt[i];
            dst   = prog_rd[i];
         end
         pipe_pkg::OP_LOAD: begin
            src_a = prog_rs[i];
            dst   = prog_rt[i];   // load writes rt
            is_ld = 1'b1;
         end
         pipe_pkg::OP_STORE: begin
            src_a = prog_rs[i];
            src_b = prog_rt[i];
         end
         pipe_pkg::OP_BEQ: begin
            src_a = prog_rs[i];
            src_b = prog_rt[i];
            ctl   = 1'b1;
         end
         pipe_pkg::OP_JR: begin
            src_a = prog_rs[i];   // rt not looked at
            ctl   = 1'b1;
         end
         default: ;
      endcase
      exp_gap[i] = 0;
      stall      = 1'b1;
      while (stall) begin
         hit_a = 1'b0;
         hit_b = 1'b0;
         for (int s = 0; s < 3; s++) begin
            hit_a = hit_a | (slot_w[s] && slot_rd[s] == src_a);
            hit_b = hit_b | (slot_w[s] && slot_rd[s] == src_b);
         end
         // load-use looks one slot back only
         stall = (slot_ld && slot_w[0] && (slot_rd[0] == src_a || slot_rd[0] == src_b))
                 || (ctl && (hit_a || hit_b));
         slot_rd[2] = slot_rd[1];
         slot_w[2]  = slot_w[1];
         slot_rd[1] = slot_rd[0];
         slot_w[1]  = slot_w[0];
         slot_rd[0] = stall ? '0 : dst;
         slot_w[0]  = !stall && dst != '0;   // r0 never counts
         slot_ld    = !stall && is_ld;
         if (stall)
            exp_gap[i]++;
      end
      total += exp_gap[i];
   end
   return total;
endfunction

//--- sim/tb_hazard_pipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "pipe_defines.svh"

module tb_hazard_pipe;

   localparam int HALT_TIMEOUT = 400;  // cycles per run
   localparam int RAND_LEN     = 40;

   logic                     i_clk;
   logic                     i_rst_n;
   logic                     i_imem_we;
   logic [`NB_IMEM_ADDR-1:0] i_imem_addr;
   logic [`NB_WORD-1:0]      i_imem_data;
   logic                     i_start;
   logic                     o_issue_valid;
   logic [`NB_WORD-1:0]      o_issue_pc;
   pipe_pkg::opcode_e        o_issue_op;
   logic                     o_bubble;
   logic                     o_halted;

   // program image, one entry per word
   pipe_pkg::opcode_e        prog_op [`IMEM_DEPTH];
   logic [`NB_REG-1:0]       prog_rs [`IMEM_DEPTH];
   logic [`NB_REG-1:0]       prog_rt [`IMEM_DEPTH];
   logic [`NB_REG-1:0]       prog_rd [`IMEM_DEPTH];
   int                       prog_len;
   int                       exp_gap [`IMEM_DEPTH]; // bubbles ahead of each issue

   logic                     mon_on;     // monitor collects while high
   logic [`NB_WORD-1:0]      got_pc [$];
   pipe_pkg::opcode_e        got_op [$];
   int                       got_gap [$];
   int                       gap_run;    // bubbles since last issue
   int                       bubble_cnt;
   int                       errors;
   int                       tests_run;
   int                       tests_failed;
   logic [31:0]              lfsr_q;

   `include "tb_hazard_model.svh"

   hazard_pipe_top DUT (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_imem_we     (i_imem_we),
      .i_imem_addr   (i_imem_addr),
      .i_imem_data   (i_imem_data),
      .i_start       (i_start),
      .o_issue_valid (o_issue_valid),
      .o_issue_pc    (o_issue_pc),
      .o_issue_op    (o_issue_op),
      .o_bubble      (o_bubble),
      .o_halted      (o_halted)
   );

   always #50 i_clk = ~i_clk;

   // outputs settle after the rising edge, sample on the falling one
   always @(negedge i_clk) begin
      if (mon_on) begin
         if (o_bubble === 1'b1) begin
            bubble_cnt++;
            gap_run++;
         end
         if (o_issue_valid === 1'b1) begin
            got_pc.push_back(o_issue_pc);
            got_op.push_back(o_issue_op);
            got_gap.push_back(gap_run);
            gap_run = 0;
         end
      end
   end

   // galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int b = 0; b < n; b++) begin
         lfsr_q = lfsr_next(lfsr_q);   // one step per bit
         v      = (v << 1) | int'(lfsr_q[0]);
      end
      return v;
   endfunction

   task automatic emit(input pipe_pkg::opcode_e op, input int rs, input int rt, input int rd);
      prog_op[prog_len] = op;
      prog_rs[prog_len] = rs[`NB_REG-1:0];
      prog_rt[prog_len] = rt[`NB_REG-1:0];
      prog_rd[prog_len] = rd[`NB_REG-1:0];
      prog_len++;
   endtask

   task automatic make_random(input int n);
      pipe_pkg::opcode_e ops [6];
      int                o;
      int                a;
      int                b;
      int                c;
      ops = '{pipe_pkg::OP_ALU, pipe_pkg::OP_LOAD, pipe_pkg::OP_STORE,
              pipe_pkg::OP_BEQ, pipe_pkg::OP_JR, pipe_pkg::OP_NOP};
      prog_len = 0;
      for (int i = 0; i < n; i++) begin
         o = rand_bits(3) % 6;   // alu and load drawn a bit more often
         a = rand_bits(3);       // r0..r7 keeps hazards dense
         b = rand_bits(3);
         c = rand_bits(3);
         emit(ops[o], a, b, c);
      end
      emit(pipe_pkg::OP_HALT, 0, 0, 0);
   endtask

   task automatic load_program();
      logic [`NB_WORD-1:0] w;
      for (int i = 0; i < prog_len; i++) begin
         w = '0;
         w[`OP_MSB -: `NB_OP]  = prog_op[i];
         w[`RS_MSB -: `NB_REG] = prog_rs[i];
         w[`RT_MSB -: `NB_REG] = prog_rt[i];
         w[`RD_MSB -: `NB_REG] = prog_rd[i];
         @(posedge i_clk);
         #1;
         i_imem_we   = 1'b1;
         i_imem_addr = i[`NB_IMEM_ADDR-1:0];
         i_imem_data = w;
      end
      @(posedge i_clk);
      #1;
      i_imem_we = 1'b0;
   endtask

   task automatic apply_reset();
      @(posedge i_clk);
      #1;
      i_rst_n = 1'b0;
      repeat (2) @(posedge i_clk);
      #1;
      i_rst_n = 1'b1;
   endtask

   task automatic pulse_start();
      @(posedge i_clk);
      #1;
      i_start = 1'b1;
      @(posedge i_clk);
      #1;
      i_start = 1'b0;
   endtask

   task automatic wait_halted(output bit ok);
      ok = 1'b0;
      for (int c = 0; c < HALT_TIMEOUT; c++) begin
         @(negedge i_clk);
         if (o_halted === 1'b1) begin
            ok = 1'b1;
            break;
         end
      end
   endtask

   // runs the loaded program and compares against the slot model
   task automatic run_check(input string name, input int want);
      int exp_total;
      int errs_before;
      bit halted;
      errs_before = errors;
      exp_total   = model_bubbles(prog_len);
      if (want >= 0) begin
         assert (exp_total == want) else begin
            $display("MISMATCH t=%0t %s: model gives %0d bubbles, rule gives %0d",
                     $time, name, exp_total, want);
            errors++;
         end
      end
      got_pc.delete();
      got_op.delete();
      got_gap.delete();
      gap_run    = 0;
      bubble_cnt = 0;
      apply_reset();      // o_halted is sticky, the image survives reset
      mon_on     = 1'b1;
      pulse_start();
      wait_halted(halted);
      if (!halted) begin
         $display("%s: pipeline never halted", name);
         errors++;
      end
      @(posedge i_clk);   // halt cycle already taken at the last falling edge
      #1;
      mon_on = 1'b0;
      assert (got_pc.size() == prog_len) else begin
         $display("MISMATCH t=%0t %s: %0d issued, expected %0d",
                  $time, name, got_pc.size(), prog_len);
         errors++;
      end
      for (int i = 0; i < got_pc.size() && i < prog_len; i++) begin
         assert (got_pc[i] == 4 * i && got_op[i] == prog_op[i] && got_gap[i] == exp_gap[i])
         else begin
            $display("MISMATCH t=%0t %s: issue %0d pc %0h %s gap %0d, expected pc %0h %s gap %0d",
                     $time, name, i, got_pc[i], got_op[i].name(), got_gap[i],
                     4 * i, prog_op[i].name(), exp_gap[i]);
            errors++;
         end
      end
      assert (bubble_cnt == exp_total) else begin
         $display("MISMATCH t=%0t %s: %0d bubbles, expected %0d",
                  $time, name, bubble_cnt, exp_total);
         errors++;
      end
      tests_run++;
      if (errors == errs_before) begin
         $display("test %-12s ok, %0d issued, %0d bubbles", name, got_pc.size(), bubble_cnt);
      end else begin
         tests_failed++;
         $display("test %-12s FAILED", name);
      end
   endtask

   initial begin
      i_clk       = 1'b0;
      i_rst_n     = 1'b1;
      i_imem_we   = 1'b0;
      i_imem_addr = '0;
      i_imem_data = '0;
      i_start     = 1'b0;
      mon_on      = 1'b0;
      gap_run     = 0;
      bubble_cnt  = 0;
      errors      = 0;
      tests_run   = 0;
      tests_failed = 0;
      prog_len    = 0;
      lfsr_q      = 32'hb9a4_5d10;
      apply_reset();

      // alu chain, forwarding covers every dependency
      prog_len = 0;
      emit(pipe_pkg::OP_ALU, 2, 3, 1);
      emit(pipe_pkg::OP_ALU, 1, 1, 4);
      emit(pipe_pkg::OP_ALU, 4, 1, 5);
      emit(pipe_pkg::OP_STORE, 5, 4, 0);
      emit(pipe_pkg::OP_HALT, 0, 0, 0);
      load_program();
      run_check("alu_chain", 0);

      // load-use right behind, then a use two slots later
      prog_len = 0;
      emit(pipe_pkg::OP_LOAD, 1, 3, 0);
      emit(pipe_pkg::OP_ALU, 3, 2, 4);
      emit(pipe_pkg::OP_LOAD, 1, 5, 0);
      emit(pipe_pkg::OP_ALU, 1, 1, 6);
      emit(pipe_pkg::OP_ALU, 2, 5, 7);
      emit(pipe_pkg::OP_HALT, 0, 0, 0);
      load_program();
      run_check("load_use", 1);

      // branch on rs or rt at writer distance d
      for (int d = 1; d <= 5; d++) begin
         prog_len = 0;
         emit(pipe_pkg::OP_ALU, 1, 2, 5);
         for (int k = 1; k < d; k++)
            emit(pipe_pkg::OP_NOP, 0, 0, 0);
         if (d % 2 == 1)
            emit(pipe_pkg::OP_BEQ, 5, 0, 0);
         else
            emit(pipe_pkg::OP_BEQ, 0, 5, 0);
         emit(pipe_pkg::OP_HALT, 0, 0, 0);
         load_program();
         run_check($sformatf("beq_dist%0d", d), (d < 4) ? 4 - d : 0);
      end

      prog_len = 0;
      emit(pipe_pkg::OP_LOAD, 1, 5, 0);
      emit(pipe_pkg::OP_BEQ, 5, 2, 0);   // load-use first, branch keeps it
      emit(pipe_pkg::OP_HALT, 0, 0, 0);
      load_program();
      run_check("load_beq", 3);

      // jump register, rs only
      for (int d = 1; d <= 4; d++) begin
         prog_len = 0;
         emit(pipe_pkg::OP_ALU, 1, 2, 6);
         for (int k = 1; k < d; k++)
            emit(pipe_pkg::OP_NOP, 0, 0, 0);
         emit(pipe_pkg::OP_JR, 6, 0, 0);
         emit(pipe_pkg::OP_HALT, 0, 0, 0);
         load_program();
         run_check($sformatf("jr_dist%0d", d), 4 - d);
      end

      prog_len = 0;
      emit(pipe_pkg::OP_ALU, 1, 2, 5);
      emit(pipe_pkg::OP_JR, 1, 5, 0);    // rt matches, no stall
      emit(pipe_pkg::OP_HALT, 0, 0, 0);
      load_program();
      run_check("jr_rt", 0);

      prog_len = 0;
      emit(pipe_pkg::OP_ALU, 1, 2, 0);   // writes r0
      emit(pipe_pkg::OP_LOAD, 1, 0, 0);
      emit(pipe_pkg::OP_BEQ, 0, 0, 0);
      emit(pipe_pkg::OP_JR, 0, 0, 0);
      emit(pipe_pkg::OP_HALT, 0, 0, 0);
      load_program();
      run_check("r0_writer", 0);

      for (int r = 0; r < 3; r++) begin
         make_random(RAND_LEN);
         load_program();
         run_check($sformatf("random%0d", r), -1);
      end

      // reset in mid-run, then a clean rerun of the same image
      make_random(RAND_LEN);
      load_program();
      pulse_start();
      repeat (8) @(posedge i_clk);
      apply_reset();
      @(negedge i_clk);
      assert (o_issue_valid === 1'b0 && o_bubble === 1'b0 && o_halted === 1'b0) else begin
         $display("MISMATCH t=%0t reset: issue %b bubble %b halted %b, expected all 0",
                  $time, o_issue_valid, o_bubble, o_halted);
         errors++;
      end
      run_check("reset_rerun", -1);

      $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- hazard_pipe_top.f
+incdir+rtl
+incdir+sim
rtl/pipe_pkg.sv
rtl/if_id_bus.sv
rtl/fetch_stage.sv
rtl/if_id_buffer.sv
rtl/decode_stage.sv
rtl/bubble_unit.sv
rtl/stage_tracker.sv
rtl/hazard_pipe_top.sv
sim/tb_hazard_pipe.sv

//--- Makefile
SIM      = verilator
TOP      = tb_hazard_pipe
FILELIST = hazard_pipe_top.f
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Testbench failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
